// ==== Makefile ====
# Verilator build and run of the POV display testbench

VERILATOR ?= verilator
TOP       ?= tb_pov_display
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= Test passed

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard include/*.svh)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run check clean

all: $(BIN)

# Rebuilt only when a source, a header or the file list changes
$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The run passes only if the pass line shows up in the output
run: $(BIN)
	@out="$$(./$(BIN) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

check: run

clean:
	rm -rf $(OBJ_DIR)

// ==== design/framebuffer.sv ====
`include "pov_consts.svh"

module framebuffer
    import pov_pixel_pkg::*;
    import pov_drive_pkg::*;
(
    input  logic                           clk_33,
    input  logic                           nrst,
    // One pulse per angular step of the rotor
    input  logic                           position_sync,
    // Read port into the slice memory
    output logic                           rd_en,
    output logic [`POV_RAM_ADDR_WIDTH-1:0] rd_addr,
    input  pixel_word_u                    rd_pixel,
    // Word for the driver controller, one per cycle
    output drive_word_t                    drive
);

    localparam int RAM_AW     = `POV_RAM_ADDR_WIDTH;
    localparam int BUFF_WORDS = `POV_BUFF_SIZE;
    localparam int BUFF_AW    = $clog2(`POV_BUFF_SIZE);
    localparam int MUX_W      = $clog2(`POV_MULTIPLEXING);
    localparam int LED_W      = $clog2(`POV_LED_PER_DRIVER);
    localparam int PLANE_W    = $clog2(`POV_POKER_MODE);
    localparam int BLANK_W    = $clog2(`POV_BLANKING_CYCLES + 1);
    localparam int SLICE_W    = $clog2(`POV_SLICES_IN_RAM);
    localparam int PAIRS      = `POV_NUM_DRIVERS / 2;

    // Pairs side by side in one band, each pair covers 8 of the 40 columns
    localparam int PAIRS_PER_BAND = `POV_ROW_SIZE / `POV_MULTIPLEXING;
    // Buffer words used by one band of 16 LED rows
    localparam int BAND_STRIDE    = PAIRS_PER_BAND * `POV_LED_PER_DRIVER;
    // Lowest plane holding a color bit, red and blue have 5 bits and green has 6
    localparam int RB_LSB_PLANE   = `POV_POKER_MODE - 5;
    localparam int G_LSB_PLANE    = `POV_POKER_MODE - 6;

    localparam logic [PLANE_W-1:0] TOP_PLANE   = PLANE_W'(`POV_POKER_MODE - 1);
    localparam logic [BLANK_W-1:0] BLANK_START = BLANK_W'(`POV_BLANKING_CYCLES);
    localparam logic [LED_W-1:0]   LAST_LED    = LED_W'(`POV_LED_PER_DRIVER - 1);
    localparam logic [SLICE_W-1:0] LAST_SLICE  = SLICE_W'(`POV_SLICES_IN_RAM - 1);
    localparam logic [BUFF_AW-1:0] LAST_WORD   = BUFF_AW'(BUFF_WORDS - 1);

    // Word w of a column buffer is slice word column + 8 * w
    // A slice is stored row after row with 40 pixels per row, so w = row * 5 + pair
    // With row = band * 16 + LED this gives w = band * 80 + LED * 5 + pair in band
    function automatic logic [BUFF_AW-1:0] pair_word(input int p, input logic [LED_W-1:0] led);
        return BUFF_AW'((p % PAIRS_PER_BAND) + (p / PAIRS_PER_BAND) * BAND_STRIDE
                        + PAIRS_PER_BAND * int'(led));
    endfunction

    // Bit of one color on one plane, the MSB goes out on the top plane
    // Planes below the color's LSB are padding and send zero
    function automatic logic color_bit(input pixel_word_u px, input color_e c,
                                       input logic [PLANE_W-1:0] plane);
        logic bit_out;
        bit_out = 1'b0;
        case (c)
            COLOR_RED: begin
                if (plane >= RB_LSB_PLANE) bit_out = px.rgb.red[plane - RB_LSB_PLANE];
            end
            COLOR_GREEN: begin
                if (plane >= G_LSB_PLANE) bit_out = px.rgb.green[plane - G_LSB_PLANE];
            end
            COLOR_BLUE: begin
                if (plane >= RB_LSB_PLANE) bit_out = px.rgb.blue[plane - RB_LSB_PLANE];
            end
            default: bit_out = 1'b0;
        endcase
        return bit_out;
    endfunction

    // Two column buffers, one is shown while the other is filled
    pixel_word_u col_buf [2][BUFF_WORDS];
    // Set once a buffer holds a complete column, until then it shows black
    logic [1:0]  buf_loaded;
    logic        front_sel;
    logic        back_sel;

    // Serializer position within the slice
    logic [MUX_W-1:0]   col_idx;
    logic [LED_W-1:0]   led_idx;
    color_e             color;
    logic [PLANE_W-1:0] plane_idx;
    // Remaining dark cycles, zero while data goes out
    logic [BLANK_W-1:0] blank_cnt;
    logic               col_start;
    logic               data_slot;

    // Fetch side
    logic [SLICE_W-1:0] slice_cnt;
    logic [SLICE_W-1:0] slice_sel;
    logic [SLICE_W-1:0] fetch_slice;
    logic [MUX_W-1:0]   next_col;
    logic [BUFF_AW-1:0] fetch_cnt;
    logic [BUFF_AW-1:0] wr_idx;
    logic               wr_en;

    // Output word build
    pixel_word_u                 pair_px [PAIRS];
    logic [PAIRS-1:0]            pair_bits;
    logic [`POV_NUM_DRIVERS-1:0] slot_bits;

    assign back_sel  = ~front_sel;
    assign col_start = (blank_cnt == BLANK_START);
    assign data_slot = (blank_cnt == '0);
    assign next_col  = col_idx + 1'b1;
    // Column 0 takes a fresh sample of the slice counter, later columns keep it
    assign fetch_slice = (next_col == '0) ? slice_cnt : slice_sel;

    // Every position pulse moves on by one slice, wrapping after the last one
    always_ff @(posedge clk_33) begin
        if (!nrst) begin
            slice_cnt <= '0;
        end else if (position_sync) begin
            slice_cnt <= (slice_cnt == LAST_SLICE) ? '0 : slice_cnt + 1'b1;
        end
    end

    // A fetch of the next column starts with each column period
    // 240 reads go out back to back and the data trails them by one cycle
    always_ff @(posedge clk_33) begin
        if (!nrst) begin
            rd_en     <= 1'b0;
            wr_en     <= 1'b0;
            fetch_cnt <= '0;
            slice_sel <= '0;
        end else begin
            wr_en <= rd_en;
            if (col_start) begin
                rd_en     <= 1'b1;
                fetch_cnt <= '0;
                if (next_col == '0) begin
                    slice_sel <= slice_cnt;
                end
            end else if (rd_en) begin
                if (fetch_cnt == LAST_WORD) begin
                    rd_en <= 1'b0;
                end else begin
                    fetch_cnt <= fetch_cnt + 1'b1;
                end
            end
        end
    end

    // Consecutive words of a column are 8 apart in the slice
    always_ff @(posedge clk_33) begin
        wr_idx <= fetch_cnt;
        if (col_start) begin
            rd_addr <= RAM_AW'(fetch_slice) * RAM_AW'(`POV_IMAGE_SIZE) + RAM_AW'(next_col);
        end else if (rd_en) begin
            rd_addr <= rd_addr + RAM_AW'(`POV_MULTIPLEXING);
        end
    end

    always_ff @(posedge clk_33) begin
        if (wr_en) begin
            col_buf[back_sel][wr_idx] <= rd_pixel;
        end
    end

    always_ff @(posedge clk_33) begin
        if (!nrst) begin
            buf_loaded <= 2'b00;
        end else if (wr_en && wr_idx == LAST_WORD) begin
            buf_loaded[back_sel] <= 1'b1;
        end
    end

    // Colors run fastest, then LEDs, then planes from the MSB down
    // A plane is followed by one dark cycle, the last one by the column blanking
    always_ff @(posedge clk_33) begin
        if (!nrst) begin
            col_idx   <= '0;
            led_idx   <= '0;
            color     <= COLOR_RED;
            plane_idx <= TOP_PLANE;
            blank_cnt <= BLANK_START;
            front_sel <= 1'b0;
        end else if (!data_slot) begin
            blank_cnt <= blank_cnt - 1'b1;
        end else if (color != COLOR_BLUE) begin
            color <= color_e'(color + 1'b1);
        end else begin
            color <= COLOR_RED;
            if (led_idx != LAST_LED) begin
                led_idx <= led_idx + 1'b1;
            end else begin
                led_idx <= '0;
                if (plane_idx != '0) begin
                    plane_idx <= plane_idx - 1'b1;
                    blank_cnt <= BLANK_W'(1);
                end else begin
                    // Column done, the freshly fetched buffer comes to the front
                    plane_idx <= TOP_PLANE;
                    col_idx   <= col_idx + 1'b1;
                    front_sel <= ~front_sel;
                    blank_cnt <= BLANK_START;
                end
            end
        end
    end

    // Each driver pair reads its own word of the current LED row
    always_comb begin
        for (int p = 0; p < PAIRS; p++) begin
            pair_px[p]   = col_buf[front_sel][pair_word(p, led_idx)];
            pair_bits[p] = color_bit(pair_px[p], color, plane_idx);
        end
    end

    // The two drivers of a pair face each other and light the same pixel
    always_comb begin
        for (int i = 0; i < `POV_NUM_DRIVERS; i++) begin
            slot_bits[i] = pair_bits[i / 2];
        end
    end

    // Output register, dark during blanking and while the front buffer is empty
    always_ff @(posedge clk_33) begin
        if (!nrst) begin
            drive <= '0;
        end else begin
            drive.sync <= col_start && (col_idx == '0);
            drive.bits <= (data_slot && buf_loaded[front_sel]) ? slot_bits : '0;
        end
    end

endmodule

// ==== design/pov_display_top.sv ====
`include "pov_consts.svh"

module pov_display_top
    import pov_pixel_pkg::*;
    import pov_drive_pkg::*;
(
    input  logic        clk_33,
    input  logic        nrst,
    // Host loads slice images here
    input  host_write_t host_wr,
    input  logic        host_valid,
    output logic        host_ready,
    // Rotor position pulse
    input  logic        position_sync,
    // Stream for the driver controller
    output drive_word_t drive
);

    // Framebuffer reads from the slice memory
    logic                           rd_en;
    logic [`POV_RAM_ADDR_WIDTH-1:0] rd_addr;
    pixel_word_u                    rd_pixel;

    slice_ram i_slice_ram (
        .clk_33     (clk_33),
        .nrst       (nrst),
        .host_wr    (host_wr),
        .host_valid (host_valid),
        .host_ready (host_ready),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .rd_pixel   (rd_pixel)
    );

    framebuffer i_framebuffer (
        .clk_33        (clk_33),
        .nrst          (nrst),
        .position_sync (position_sync),
        .rd_en         (rd_en),
        .rd_addr       (rd_addr),
        .rd_pixel      (rd_pixel),
        .drive         (drive)
    );

endmodule

// ==== design/pov_drive_pkg.sv ====
`include "pov_consts.svh"

package pov_drive_pkg;

    // One beat on the host write port
    typedef struct packed {
        // Word address over all slices
        logic [`POV_RAM_ADDR_WIDTH-1:0] addr;
        // RGB565 pixel as raw bits
        logic [15:0]                    pixel;
    } host_write_t;

    // Word handed to the driver controller on every cycle
    typedef struct packed {
        // High on the first blanking cycle of column 0 only
        logic                        sync;
        // One bit per driver, the drivers of a pair carry the same bit
        logic [`POV_NUM_DRIVERS-1:0] bits;
    } drive_word_t;

endpackage

// ==== design/pov_pixel_pkg.sv ====
package pov_pixel_pkg;

    // RGB565 as the host packs it, red sits in the top five bits
    typedef struct packed {
        logic [4:0] red;
        logic [5:0] green;
        logic [4:0] blue;
    } rgb565_t;

    // The host and the memory deal in raw words
    // The serializer picks the same word apart into its color fields
    typedef union packed {
        logic [15:0] raw;
        rgb565_t     rgb;
    } pixel_word_u;

    // Color slot inside one LED, sent in this order
    typedef enum logic [1:0] {
        COLOR_RED   = 2'd0,
        COLOR_GREEN = 2'd1,
        COLOR_BLUE  = 2'd2
    } color_e;

endpackage

// ==== design/slice_ram.sv ====
`include "pov_consts.svh"

module slice_ram
    import pov_pixel_pkg::*;
    import pov_drive_pkg::*;
(
    input  logic                           clk_33,
    input  logic                           nrst,
    // Host side write port
    input  host_write_t                    host_wr,
    input  logic                           host_valid,
    output logic                           host_ready,
    // Framebuffer side read port
    input  logic                           rd_en,
    input  logic [`POV_RAM_ADDR_WIDTH-1:0] rd_addr,
    output pixel_word_u                    rd_pixel
);

    localparam int RAM_WORDS = `POV_SLICES_IN_RAM * `POV_IMAGE_SIZE;

    // All slices back to back, slice s starts at word s * 1920
    pixel_word_u mem [RAM_WORDS];

    // Address of the last accepted read
    logic [`POV_RAM_ADDR_WIDTH-1:0] rd_addr_q;

    // The port stays closed during reset and opens on the first cycle after it
    always_ff @(posedge clk_33) begin
        if (!nrst) begin
            host_ready <= 1'b0;
        end else begin
            host_ready <= 1'b1;
        end
    end

    // A write lands on a cycle where valid meets ready
    // Beats aimed past the last slice are accepted and dropped
    always_ff @(posedge clk_33) begin
        if (host_valid && host_ready && host_wr.addr < RAM_WORDS) begin
            mem[host_wr.addr].raw <= host_wr.pixel;
        end
    end

    // The read address is captured on rd_en
    // The word shows up on the cycle after the request
    always_ff @(posedge clk_33) begin
        if (rd_en) begin
            rd_addr_q <= rd_addr;
        end
    end

    assign rd_pixel = mem[rd_addr_q];

endmodule

// ==== filelist.f ====
+incdir+include
design/pov_pixel_pkg.sv
design/pov_drive_pkg.sv
design/slice_ram.sv
design/framebuffer.sv
design/pov_display_top.sv
sim/pov_asserts.sv
sim/tb_pov_display.sv

// ==== include/pov_consts.svh ====
`ifndef POV_CONSTS_SVH
`define POV_CONSTS_SVH

// Each driver owns a column of 16 LEDs
`define POV_LED_PER_DRIVER 16
// A driver shows 8 columns in turn within one slice
`define POV_MULTIPLEXING 8
// Columns lit at once, the facing drivers of a pair show the same pixel
`define POV_ROW_SIZE 40
// LED rows over the three driver bands
`define POV_COLUMN_SIZE 48
// Words in one slice image, row after row of 40 pixels
`define POV_IMAGE_SIZE 1920
// Slices held in the on-chip memory
`define POV_SLICES_IN_RAM 18
`define POV_RAM_ADDR_WIDTH 16

// Bit planes sent per column in poker mode
`define POV_POKER_MODE 9
// Dark cycles when the drivers move on to the next column
`define POV_BLANKING_CYCLES 72

// One output bit per LED driver
`define POV_NUM_DRIVERS 30
// Words fetched for one column, 15 driver pairs of 16 LEDs
`define POV_BUFF_SIZE 240

`endif

// ==== sim/pov_asserts.sv ====
`include "pov_consts.svh"

module pov_asserts
    import pov_drive_pkg::*;
(
    input logic                                  clk_33,
    input logic                                  nrst,
    input drive_word_t                           drive,
    input logic [$clog2(`POV_SLICES_IN_RAM)-1:0] slice_cnt
);

    // Blanking, nine planes of 16 LEDs times three colors, one dark cycle between planes
    localparam int COLUMN_CYCLES = `POV_BLANKING_CYCLES
                                   + `POV_POKER_MODE * (`POV_LED_PER_DRIVER * 3 + 1) - 1;
    localparam int SLICE_CYCLES  = `POV_MULTIPLEXING * COLUMN_CYCLES;
    localparam int GAP_W         = $clog2(SLICE_CYCLES) + 1;

    // Cycles since the last sync word, valid once the first sync was seen
    logic [GAP_W-1:0] since_sync;
    logic             seen_sync;
    // Read by the testbench for its final verdict
    int               fail_count = 0;

    always_ff @(posedge clk_33) begin
        if (!nrst) begin
            since_sync <= '0;
            seen_sync  <= 1'b0;
        end else if (drive.sync) begin
            since_sync <= '0;
            seen_sync  <= 1'b1;
        end else if (seen_sync) begin
            since_sync <= since_sync + 1'b1;
        end
    end

    // Sync is a single cycle flag
    sync_single: assert property (@(posedge clk_33) disable iff (!nrst)
        drive.sync |=> !drive.sync)
        else begin
            fail_count++;
            $error("sync stayed high for more than one cycle");
        end

    // Consecutive syncs are one slice apart
    sync_period: assert property (@(posedge clk_33) disable iff (!nrst)
        (drive.sync && seen_sync) |-> (since_sync == GAP_W'(SLICE_CYCLES - 1)))
        else begin
            fail_count++;
            $error("sync came back after %0d cycles", since_sync + 1);
        end

    // No sync may go missing either
    sync_missing: assert property (@(posedge clk_33) disable iff (!nrst)
        seen_sync |-> (since_sync < GAP_W'(SLICE_CYCLES)))
        else begin
            fail_count++;
            $error("no sync within one slice period");
        end

    // The sync word and the rest of the column 0 blanking are dark
    sync_blank: assert property (@(posedge clk_33) disable iff (!nrst)
        (drive.sync || (seen_sync && since_sync < GAP_W'(`POV_BLANKING_CYCLES - 1)))
        |-> (drive.bits == '0))
        else begin
            fail_count++;
            $error("LED bits set during the blanking after sync");
        end

    slice_range: assert property (@(posedge clk_33) disable iff (!nrst)
        slice_cnt < `POV_SLICES_IN_RAM)
        else begin
            fail_count++;
            $error("slice counter left the range of stored slices");
        end

endmodule

// ==== sim/tb_pov_display.sv ====
`include "pov_consts.svh"

module tb_pov_display
    import pov_pixel_pkg::*;
    import pov_drive_pkg::*;
();

    localparam int RAM_WORDS      = `POV_SLICES_IN_RAM * `POV_IMAGE_SIZE;
    localparam int LOAD_WORDS     = 3 * `POV_IMAGE_SIZE;
    localparam int PAIRS_PER_BAND = `POV_ROW_SIZE / `POV_MULTIPLEXING;
    localparam int BAND_STRIDE    = PAIRS_PER_BAND * `POV_LED_PER_DRIVER;
    localparam int PLANE_CYCLES   = `POV_LED_PER_DRIVER * 3;
    // A plane and the dark cycle behind it
    localparam int PLANE_SLOT     = PLANE_CYCLES + 1;
    localparam int COLUMN_CYCLES  = `POV_BLANKING_CYCLES + `POV_POKER_MODE * PLANE_SLOT - 1;
    localparam int SLICE_CYCLES   = `POV_MULTIPLEXING * COLUMN_CYCLES;
    // Red and blue have 5 bits and green has 6
    // All colors go out MSB first from the top plane
    localparam int RB_LSB_PLANE   = `POV_POKER_MODE - 5;
    localparam int G_LSB_PLANE    = `POV_POKER_MODE - 6;
    localparam int CHECK_SLICES   = 4;
    // Load plus reset slack and then two skipped and four checked slices
    // The slice part is doubled for margin
    localparam int LOAD_CYCLES    = LOAD_WORDS + 40;
    localparam int TIMEOUT_CYCLES = LOAD_CYCLES + 2 * (CHECK_SLICES + 2) * SLICE_CYCLES;

    logic        clk_33;
    logic        nrst;
    host_write_t host_wr;
    logic        host_valid;
    logic        host_ready;
    logic        position_sync;
    drive_word_t drive;

    // Copy of what the host writes to slices 0 to 2
    logic [15:0] model [RAM_WORDS];
    integer      seed;
    int          mismatch_errors = 0;
    int          other_errors = 0;
    int          words_checked = 0;
    // Green plane 3 words where the DUT set at least one bit
    int          green_lsb_words = 0;
    // Cycles where a load beat had to wait for host_ready
    int          load_stalls = 0;
    int          cycle_count = 0;
    int          wait_count;
    int          period_idx = -1;
    bit          load_done = 1'b0;
    // Slice shown in each checked period and the name used in its error lines
    int          exp_slice [CHECK_SLICES] = '{0, 0, 1, 0};
    string       period_name [CHECK_SLICES] = '{"slice0", "slice0_again", "position", "wrap"};

    pov_display_top i_dut (
        .clk_33        (clk_33),
        .nrst          (nrst),
        .host_wr       (host_wr),
        .host_valid    (host_valid),
        .host_ready    (host_ready),
        .position_sync (position_sync),
        .drive         (drive)
    );

    bind framebuffer pov_asserts i_pov_asserts (
        .clk_33    (clk_33),
        .nrst      (nrst),
        .drive     (drive),
        .slice_cnt (slice_cnt)
    );

    initial begin
        clk_33 = 1'b0;
        forever #10 clk_33 = ~clk_33;
    end

    // Expected driver bits for one output slot
    // Driver i belongs to pair i/2
    // A pair sits in one of three bands of 16 rows
    function automatic logic [`POV_NUM_DRIVERS-1:0] expected_bits(input int slice,
            input int col, input int led, input int color, input int plane);
        logic [`POV_NUM_DRIVERS-1:0] bits;
        logic [15:0]                 px;
        int                          p;
        int                          w;
        bits = '0;
        for (int i = 0; i < `POV_NUM_DRIVERS; i++) begin
            p  = i / 2;
            w  = (p % PAIRS_PER_BAND) + BAND_STRIDE * (p / PAIRS_PER_BAND) + PAIRS_PER_BAND * led;
            px = model[slice * `POV_IMAGE_SIZE + col + `POV_MULTIPLEXING * w];
            // RGB565 holds red in 15:11, green in 10:5 and blue in 4:0
            if (color == int'(COLOR_RED) && plane >= RB_LSB_PLANE) begin
                bits[i] = px[11 + plane - RB_LSB_PLANE];
            end else if (color == int'(COLOR_GREEN) && plane >= G_LSB_PLANE) begin
                bits[i] = px[5 + plane - G_LSB_PLANE];
            end else if (color == int'(COLOR_BLUE) && plane >= RB_LSB_PLANE) begin
                bits[i] = px[plane - RB_LSB_PLANE];
            end
        end
        return bits;
    endfunction

    task automatic report_mismatch(input string test, input logic [31:0] exp,
            input logic [31:0] act);
        mismatch_errors++;
        $display("mismatch %s: expected %h, actual %h (period %0d)", test, exp, act, period_idx);
    endtask

    // Sends one beat and holds it until the RAM takes it
    task automatic write_beat(input int addr, input logic [15:0] pixel);
        host_wr.addr  = 16'(addr);
        host_wr.pixel = pixel;
        host_valid    = 1'b1;
        while (!host_ready) begin
            load_stalls++;
            @(posedge clk_33);
            #2;
        end
        @(posedge clk_33);
        #2;
    endtask

    task automatic pulse_position(input int count);
        repeat (count) begin
            @(posedge clk_33);
            #2;
            position_sync = 1'b1;
            @(posedge clk_33);
            #2;
            position_sync = 1'b0;
        end
    endtask

    // Moves on by at least one cycle and stops on the next sync word
    task automatic wait_sync();
        @(negedge clk_33);
        while (!drive.sync) begin
            @(negedge clk_33);
        end
    endtask

    // Walks one slice from its sync word with one output word per cycle
    task automatic check_slice(input int slice, input string name);
        int                          col;
        int                          r;
        int                          d;
        int                          plane;
        int                          led;
        int                          color;
        string                       test;
        logic [`POV_NUM_DRIVERS-1:0] exp_bits;
        logic [`POV_NUM_DRIVERS-1:0] paired;
        for (int k = 0; k < SLICE_CYCLES; k++) begin
            col      = k / COLUMN_CYCLES;
            r        = k % COLUMN_CYCLES;
            exp_bits = '0;
            test     = "blanking";
            if (r >= `POV_BLANKING_CYCLES) begin
                d = r - `POV_BLANKING_CYCLES;
                // The last slot of each plane slot is the dark cycle
                if (d % PLANE_SLOT != PLANE_CYCLES) begin
                    plane    = `POV_POKER_MODE - 1 - d / PLANE_SLOT;
                    led      = (d % PLANE_SLOT) / 3;
                    color    = (d % PLANE_SLOT) % 3;
                    exp_bits = expected_bits(slice, col, led, color, plane);
                    if (color == int'(COLOR_GREEN) && plane == G_LSB_PLANE) begin
                        test = "green_lsb";
                        if (drive.bits != '0) begin
                            green_lsb_words++;
                        end
                    end else if (plane < RB_LSB_PLANE) begin
                        test = "padding";
                    end else begin
                        test = name;
                    end
                end
            end
            for (int p = 0; p < `POV_NUM_DRIVERS / 2; p++) begin
                paired[2 * p]     = drive.bits[2 * p];
                paired[2 * p + 1] = drive.bits[2 * p];
            end
            assert (drive.sync == (k == 0))
                else report_mismatch("sync", 32'(k == 0), 32'(drive.sync));
            assert (drive.bits == exp_bits)
                else report_mismatch(test, 32'(exp_bits), 32'(drive.bits));
            assert (drive.bits == paired)
                else report_mismatch("pairing", 32'(paired), 32'(drive.bits));
            words_checked++;
            @(negedge clk_33);
        end
    endtask

    task automatic finish_run();
        int assert_fails;
        assert_fails = i_dut.i_framebuffer.i_pov_asserts.fail_count;
        $display("errors: %0d mismatch, %0d other, %0d assertion, %0d words checked",
                 mismatch_errors, other_errors, assert_fails, words_checked);
        if (mismatch_errors == 0 && other_errors == 0 && assert_fails == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    // Reset, image load and the position pulses
    initial begin
        nrst          = 1'b0;
        host_wr       = '0;
        host_valid    = 1'b0;
        position_sync = 1'b0;
        seed          = 32'h8672_4e10;
        for (int a = 0; a < LOAD_WORDS; a++) begin
            model[a] = 16'($random(seed));
        end
        repeat (2) @(posedge clk_33);
        #2;
        assert (drive == '0) else report_mismatch("reset_drive", 32'd0, 32'(drive));
        assert (!host_ready) else report_mismatch("reset_ready", 32'd0, 32'(host_ready));
        nrst       = 1'b1;
        wait_count = 0;
        while (!host_ready && wait_count < 4) begin
            @(posedge clk_33);
            #2;
            wait_count++;
        end
        assert (host_ready) else begin
            other_errors++;
            $display("error: host_ready did not rise after reset");
        end
        for (int a = 0; a < LOAD_WORDS; a++) begin
            write_beat(a, model[a]);
        end
        host_valid = 1'b0;
        // The port stays open once reset is over and no beat ever waits
        assert (load_stalls == 0) else begin
            other_errors++;
            $display("error: host_ready was low for %0d cycles during the image load",
                     load_stalls);
        end
        load_done = 1'b1;
        // Pulses early in a period so that the column 0 fetch of the next period sees the count
        wait (period_idx == 1);
        pulse_position(1);
        wait (period_idx == 2);
        pulse_position(`POV_SLICES_IN_RAM - 1);
    end

    // Comparison of every output word against the reference
    initial begin
        wait (load_done);
        // The period after the first sync may still show columns fetched during the load
        wait_sync();
        wait_sync();
        for (int k = 0; k < CHECK_SLICES; k++) begin
            period_idx = k;
            check_slice(exp_slice[k], period_name[k]);
        end
        assert (green_lsb_words > 0) else begin
            other_errors++;
            $display("error: green plane 3 never carried a set bit");
        end
        finish_run();
    end

    initial begin
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk_33);
            cycle_count++;
        end
        other_errors++;
        $display("error: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        finish_run();
    end

endmodule
